// ==== Bender.yml ====
package:
  name: debug_hex

sources:
  - src/debug_pkg.sv
  - src/msg_if.sv
  - src/bits_to_hex.sv
  - src/probe_port.sv
  - src/msg_arbiter.sv
  - src/line_formatter.sv
  - src/uart_tx.sv
  - src/debug_hex_top.sv
  - target: simulation
    files:
      - testbench/debug_hex_monitor.sv
      - testbench/debug_hex_checker.sv
      - testbench/tb_debug_hex.sv

// ==== build.f ====
src/debug_pkg.sv
src/msg_if.sv
src/bits_to_hex.sv
src/probe_port.sv
src/msg_arbiter.sv
src/line_formatter.sv
src/uart_tx.sv
src/debug_hex_top.sv
testbench/debug_hex_monitor.sv
testbench/debug_hex_checker.sv
testbench/tb_debug_hex.sv

// ==== src/bits_to_hex.sv ====
// Registered binary to ASCII hex converter, one output byte per nibble of the input
`timescale 1ns/1ps

module bits_to_hex #(
  parameter int VALUE_BITS = 32
) (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                [VALUE_BITS-1:0]          bits_i,
  output debug_pkg::ascii_t   [(VALUE_BITS+3)/4-1:0]    ascii_o
);

  // Ceiling of VALUE_BITS / 4
  localparam int N_DIGITS = (VALUE_BITS + 3) / 4;
  // Input widened to whole nibbles
  localparam int PAD_BITS = 4 * N_DIGITS;

  logic [PAD_BITS-1:0] padded;

  // Partial top nibble gets zeros above the input MSB
  assign padded = PAD_BITS'(bits_i);

  // 0-9 map from "0", 10-15 map from "A"
  function automatic debug_pkg::ascii_t nibble_to_ascii(input logic [3:0] nib);
    if (nib < 4'd10) begin
      return 8'h30 + {4'h0, nib};
    end else begin
      // "A" minus ten
      return 8'h37 + {4'h0, nib};
    end
  endfunction

  // Digit i holds nibble i, so the least significant digit sits in byte 0
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      ascii_o <= '0;
    end else begin
      for (int i = 0; i < N_DIGITS; i++) begin
        ascii_o[i] <= nibble_to_ascii(padded[4*i +: 4]);
      end
    end
  end

endmodule

// ==== src/debug_hex_top.sv ====
// Debug reporter top level, two probe channels printed as hex text lines on one UART line
`timescale 1ns/1ps

module debug_hex_top #(
  parameter int VALUE_BITS   = 32,
  parameter int CLKS_PER_BIT = 868
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  strobe0_i,
  input  logic [VALUE_BITS-1:0] value0_i,
  input  logic                  strobe1_i,
  input  logic [VALUE_BITS-1:0] value1_i,
  output logic                  tx_o,
  output logic                  idle_o
);

  msg_if #(.VALUE_BITS(VALUE_BITS)) msg0 ();
  msg_if #(.VALUE_BITS(VALUE_BITS)) msg1 ();

  logic                  start;
  debug_pkg::channel_t   channel;
  logic [VALUE_BITS-1:0] value;
  logic                  overrun;
  logic                  fmt_busy;
  logic                  send;
  debug_pkg::ascii_t     char_q;
  logic                  tx_busy;

  probe_port #(.VALUE_BITS(VALUE_BITS)) u_probe0 (
    .clk_i(clk_i), .reset_i(reset_i), .strobe_i(strobe0_i), .value_i(value0_i), .msg(msg0.probe)
  );

  probe_port #(.VALUE_BITS(VALUE_BITS)) u_probe1 (
    .clk_i(clk_i), .reset_i(reset_i), .strobe_i(strobe1_i), .value_i(value1_i), .msg(msg1.probe)
  );

  msg_arbiter #(.VALUE_BITS(VALUE_BITS)) u_msg_arbiter (
    .clk_i(clk_i), .reset_i(reset_i), .msg0(msg0.arbiter), .msg1(msg1.arbiter),
    .fmt_busy_i(fmt_busy), .start_o(start), .channel_o(channel), .value_o(value),
    .overrun_o(overrun)
  );

  line_formatter #(.VALUE_BITS(VALUE_BITS)) u_line_formatter (
    .clk_i(clk_i), .reset_i(reset_i), .start_i(start), .channel_i(channel), .value_i(value),
    .overrun_i(overrun), .tx_busy_i(tx_busy), .send_o(send), .char_o(char_q), .busy_o(fmt_busy)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
    .clk_i(clk_i), .reset_i(reset_i), .send_i(send), .char_i(char_q), .busy_o(tx_busy),
    .tx_o(tx_o)
  );

  // Nothing waiting at the probes and no line being built
  assign idle_o = !msg0.req && !msg1.req && !fmt_busy;

endmodule

// ==== src/debug_pkg.sv ====
// Shared character type, channel number, report characters and FSM state encodings
package debug_pkg;

  // One ASCII character on the way to the serial line
  typedef logic [7:0] ascii_t;

  // Probe channel number, two channels
  typedef logic [0:0] channel_t;

  // Separator after the channel digit of a normal report
  localparam ascii_t CHR_SEP = 8'h3A;
  // Separator when the report replaced an earlier, unsent value
  localparam ascii_t CHR_OVR = 8'h21;
  // Line feed closing each report
  localparam ascii_t CHR_EOL = 8'h0A;

  // Line formatter sequence
  typedef enum logic [1:0] {
    FMT_IDLE,
    FMT_CONVERT,
    FMT_SEND,
    FMT_WAIT
  } fmt_state_t;

  // Transmitter frame phases
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

endpackage

// ==== src/line_formatter.sv ====
// Builds one report line per start and hands its characters one by one to the UART transmitter
`timescale 1ns/1ps

module line_formatter #(
  parameter int VALUE_BITS = 32
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  start_i,
  input  debug_pkg::channel_t   channel_i,
  input  logic [VALUE_BITS-1:0] value_i,
  input  logic                  overrun_i,
  input  logic                  tx_busy_i,
  output logic                  send_o,
  output debug_pkg::ascii_t     char_o,
  output logic                  busy_o
);

  localparam int N_DIGITS = (VALUE_BITS + 3) / 4;
  // Channel digit, separator, hex digits, line feed
  localparam int N_CHARS  = N_DIGITS + 3;
  localparam int IDX_W    = $clog2(N_CHARS + 1);

  debug_pkg::fmt_state_t                  state;
  // Number of characters already accepted by the transmitter
  logic [IDX_W-1:0]                       idx;
  debug_pkg::channel_t                    channel_q;
  logic                                   overrun_q;
  logic [VALUE_BITS-1:0]                  value_q;
  debug_pkg::ascii_t     [N_DIGITS-1:0]   digits;

  // Converter sees value_i in the start cycle and the held copy after that
  // so its output is valid one cycle after start and then stays put
  bits_to_hex #(
    .VALUE_BITS(VALUE_BITS)
  ) u_bits_to_hex (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .bits_i (start_i ? value_i : value_q),
    .ascii_o(digits)
  );

  // Report content held for the whole line
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      value_q   <= value_i;
      channel_q <= channel_i;
      overrun_q <= overrun_i;
    end
  end

  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      state <= debug_pkg::FMT_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        debug_pkg::FMT_IDLE: begin
          if (start_i) begin
            state <= debug_pkg::FMT_CONVERT;
            idx   <= '0;
          end
        end
        // Converter output settles here
        debug_pkg::FMT_CONVERT: state <= debug_pkg::FMT_SEND;
        debug_pkg::FMT_SEND: begin
          if (!tx_busy_i) begin
            idx   <= idx + 1'b1;
            state <= debug_pkg::FMT_WAIT;
          end
        end
        // One cycle gap after each send, transmitter busy rises meanwhile
        debug_pkg::FMT_WAIT: begin
          state <= (idx == IDX_W'(N_CHARS)) ? debug_pkg::FMT_IDLE : debug_pkg::FMT_SEND;
        end
        default: state <= debug_pkg::FMT_IDLE;
      endcase
    end
  end

  assign busy_o = (state != debug_pkg::FMT_IDLE);
  assign send_o = (state == debug_pkg::FMT_SEND) && !tx_busy_i;

  // Character for the current position, hex digits go out MSB first
  always_comb begin
    int digit;
    digit = N_DIGITS + 1 - int'(idx);
    if (idx == '0) begin
      char_o = 8'h30 + {7'b0, channel_q};
    end else if (idx == IDX_W'(1)) begin
      char_o = overrun_q ? debug_pkg::CHR_OVR : debug_pkg::CHR_SEP;
    end else if (idx <= IDX_W'(N_DIGITS + 1)) begin
      char_o = digits[digit];
    end else begin
      char_o = debug_pkg::CHR_EOL;
    end
  end

endmodule

// ==== src/msg_arbiter.sv ====
// Round-robin arbiter that passes one pending probe report at a time to the line formatter
`timescale 1ns/1ps

module msg_arbiter #(
  parameter int VALUE_BITS = 32
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  msg_if.arbiter                msg0,
  msg_if.arbiter                msg1,
  input  logic                  fmt_busy_i,
  output logic                  start_o,
  output debug_pkg::channel_t   channel_o,
  output logic [VALUE_BITS-1:0] value_o,
  output logic                  overrun_o
);

  // Channel that got the most recent grant
  debug_pkg::channel_t last_served;
  logic                pick1;

  // Channel 1 wins alone, or on a tie when channel 0 went last
  assign pick1 = msg1.req && (!msg0.req || !last_served[0]);

  // Start and grant in the same cycle, only while the formatter is free
  assign start_o    = (msg0.req || msg1.req) && !fmt_busy_i;
  assign msg0.grant = start_o && !pick1;
  assign msg1.grant = start_o && pick1;

  // Forward the content of the chosen request with the start strobe
  assign channel_o = pick1;
  assign value_o   = pick1 ? msg1.value : msg0.value;
  assign overrun_o = pick1 ? msg1.overrun : msg0.overrun;

  // Channel 1 counts as served first, so channel 0 wins the first tie
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      last_served <= 1'b1;
    end else if (start_o) begin
      last_served <= pick1;
    end
  end

endmodule

// ==== src/msg_if.sv ====
// Request path from one probe channel to the arbiter, instantiated once per channel
`timescale 1ns/1ps

interface msg_if #(
  parameter int VALUE_BITS = 32
);

  // Report pending, held until granted
  logic                  req;
  // Captured probe value, stable while req is high
  logic [VALUE_BITS-1:0] value;
  // An earlier value was replaced before its report went out
  logic                  overrun;
  // Arbiter takes the report in this cycle
  logic                  grant;

  // Probe side owns the request and its content
  modport probe (output req, output value, output overrun, input grant);

  // Arbiter side only answers with the grant
  modport arbiter (input req, input value, input overrun, output grant);

endinterface

// ==== src/probe_port.sv ====
// Probe channel front end, captures a strobed value and holds the report request until granted
`timescale 1ns/1ps

module probe_port #(
  parameter int VALUE_BITS = 32
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  strobe_i,
  input  logic [VALUE_BITS-1:0] value_i,
  msg_if.probe                  msg
);

  // Request and overrun flag are control state
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      msg.req     <= 1'b0;
      msg.overrun <= 1'b0;
    end else if (strobe_i) begin
      // New value always raises req
      msg.req     <= 1'b1;
      // Replacing a value that was never granted loses a report
      // A strobe in the grant cycle starts a fresh request
      msg.overrun <= msg.req && !msg.grant;
    end else if (msg.grant) begin
      msg.req     <= 1'b0;
      msg.overrun <= 1'b0;
    end
  end

  // Latest strobed value wins
  always_ff @(posedge clk_i) begin
    if (strobe_i) begin
      msg.value <= value_i;
    end
  end

endmodule

// ==== src/uart_tx.sv ====
// 8N1 UART transmitter, sends one character frame per send strobe
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              send_i,
  input  debug_pkg::ascii_t char_i,
  output logic              busy_o,
  output logic              tx_o
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  debug_pkg::tx_state_t state;
  logic [CNT_W-1:0]     cnt;
  logic [2:0]           bit_idx;
  debug_pkg::ascii_t    shift;
  logic                 bit_end;

  // Last cycle of the current bit period
  assign bit_end = (cnt == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      state   <= debug_pkg::TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      cnt <= bit_end ? '0 : cnt + 1'b1;
      case (state)
        debug_pkg::TX_IDLE: begin
          // Bit timing restarts with every frame
          cnt     <= '0;
          bit_idx <= '0;
          if (send_i) state <= debug_pkg::TX_START;
        end
        debug_pkg::TX_START: if (bit_end) state <= debug_pkg::TX_DATA;
        debug_pkg::TX_DATA: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= debug_pkg::TX_STOP;
          end
        end
        debug_pkg::TX_STOP: if (bit_end) state <= debug_pkg::TX_IDLE;
        default: state <= debug_pkg::TX_IDLE;
      endcase
    end
  end

  // LSB first, shifted out at the end of each data bit
  always_ff @(posedge clk_i) begin
    if (state == debug_pkg::TX_IDLE && send_i) begin
      shift <= char_i;
    end else if (state == debug_pkg::TX_DATA && bit_end) begin
      shift <= shift >> 1;
    end
  end

  assign busy_o = (state != debug_pkg::TX_IDLE);

  // Line idles high, start bit low, stop bit high
  always_comb begin
    case (state)
      debug_pkg::TX_START: tx_o = 1'b0;
      debug_pkg::TX_DATA:  tx_o = shift[0];
      default:             tx_o = 1'b1;
    endcase
  end

endmodule

// ==== testbench/debug_hex_checker.sv ====
// Concurrent assertions on the formatter to transmitter handshake, bound into the DUT top level
`timescale 1ns/1ps

module debug_hex_checker (
  input logic clk_i,
  input logic reset_i,
  input logic start_i,
  input logic fmt_busy_i,
  input logic send_i,
  input logic tx_busy_i,
  input logic tx_i
);

  // Count of failed assertions
  int fail_count = 0;

  // Transmitter takes a character only while it is free
  send_while_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    send_i |-> !tx_busy_i)
    else begin
      fail_count++;
      $error("Character sent while the transmitter was busy");
    end

  // Idle line is held at the stop level
  idle_line_high: assert property (@(posedge clk_i) disable iff (reset_i)
    !tx_busy_i |-> tx_i)
    else begin
      fail_count++;
      $error("Serial line low while the transmitter was idle");
    end

  // Arbiter hands over a report only to a free formatter
  start_while_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    start_i |-> !fmt_busy_i)
    else begin
      fail_count++;
      $error("Report started while the formatter was busy");
    end

endmodule

bind debug_hex_top debug_hex_checker u_checker (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .start_i   (start),
  .fmt_busy_i(fmt_busy),
  .send_i    (send),
  .tx_busy_i (tx_busy),
  .tx_i      (tx_o)
);

// ==== testbench/debug_hex_input.txt ====
# wait_cycles channel value_hex flag
# flag: 0 normal report, 1 overrun report, S superseded by a later strobe
10 0 DEADBEEF 0
1200 1 01234567 0
1200 0 89ABCDEF 0
1200 1 00000000 0
1200 0 FFFFFFFF 0
1200 1 CAFE0123 0
5 0 11111111 S
50 0 A5A5A5A5 1
1500 0 0F0F0F0F 0
0 1 F0F0F0F0 0
1200 0 13579BDF 0
0 1 2468ACE0 0
1200 0 FEDCBA98 0
0 1 76543210 0

// ==== testbench/debug_hex_monitor.sv ====
// Serial line monitor, decodes 8N1 frames into report lines and compares them per channel
`timescale 1ns/1ps

module debug_hex_monitor #(
  parameter int CLKS_PER_BIT = 4
) (
  input logic clk_i,
  input logic reset_i,
  input logic tx_i,
  input logic idle_i,
  input logic quiet_i
);

  localparam int HALF_BIT = CLKS_PER_BIT / 2;

  // Expected lines without the line feed, one queue per channel
  string exp0[$];
  string exp1[$];
  // Characters of the line being received
  string cur = "";
  int    error_count = 0;
  int    line_count = 0;

  task automatic push_expected(input bit ch, input string s);
    if (ch) begin
      exp1.push_back(s);
    end else begin
      exp0.push_back(s);
    end
  endtask

  function automatic int pending();
    return exp0.size() + exp1.size();
  endfunction

  // Channel digit picks the queue, order only matters within one channel
  task automatic check_line(input string got);
    string exp;
    bit    ch;
    line_count++;
    if (got.len() == 0 || (got[0] != "0" && got[0] != "1")) begin
      error_count++;
      $display("ERROR @ %0t: line '%s' has no valid channel digit", $time, got);
    end else begin
      ch = (got[0] == "1");
      if ((ch && exp1.size() == 0) || (!ch && exp0.size() == 0)) begin
        error_count++;
        $display("ERROR @ %0t: unexpected line '%s'", $time, got);
      end else begin
        if (ch) begin
          exp = exp1.pop_front();
        end else begin
          exp = exp0.pop_front();
        end
        if (got != exp) begin
          error_count++;
          $display("ERROR @ %0t: got '%s', expected '%s'", $time, got, exp);
        end
        // Round robin keeps the other channel at most one report behind
        if ((ch && exp0.size() > 1) || (!ch && exp1.size() > 1)) begin
          error_count++;
          $display("ERROR @ %0t: channel %0d starved behind '%s'", $time, !ch, got);
        end
      end
    end
  endtask

  // Sample each bit near its middle, starting from the first low cycle
  initial begin : decode
    logic [7:0] c;
    forever begin
      @(posedge clk_i);
      if (!reset_i && !tx_i) begin
        repeat (HALF_BIT) @(posedge clk_i);
        if (tx_i) begin
          error_count++;
          $display("ERROR @ %0t: start bit ended early", $time);
        end else begin
          for (int b = 0; b < 8; b++) begin
            repeat (CLKS_PER_BIT) @(posedge clk_i);
            c[b] = tx_i;
          end
          repeat (CLKS_PER_BIT) @(posedge clk_i);
          if (!tx_i) begin
            error_count++;
            $display("ERROR @ %0t: stop bit low after character %h", $time, c);
          end else if (c == 8'h0A) begin
            check_line(cur);
            cur = "";
          end else begin
            cur = $sformatf("%s%c", cur, c);
          end
        end
      end
    end
  end

  // After the last report nothing may move
  always @(posedge clk_i) begin
    if (quiet_i && !(idle_i && tx_i)) begin
      error_count++;
      $display("ERROR @ %0t: activity after last report, idle %b tx %b", $time, idle_i, tx_i);
    end
  end

endmodule

// ==== testbench/tb_debug_hex.sv ====
// Testbench top for the debug hex reporter, replays the event file and prints the result
`timescale 1ns/1ps

module tb_debug_hex;

  localparam int CLKS_PER_BIT = 4;
  // One report of 11 characters, 10 bits each, at the testbench bit period
  localparam int REPORT_CYCLES = 11 * 40;
  localparam logic [31:0] SEED = 32'hcf9e_489f;

  logic        clk;
  logic        reset;
  logic        strobe0;
  logic [31:0] value0;
  logic        strobe1;
  logic [31:0] value1;
  logic        tx;
  logic        idle;
  logic        quiet;
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 0;
  int          file_errors = 0;
  int          total_errors;

  debug_hex_top #(.VALUE_BITS(32), .CLKS_PER_BIT(CLKS_PER_BIT)) u_debug_hex_top (
    .clk_i(clk), .reset_i(reset), .strobe0_i(strobe0), .value0_i(value0),
    .strobe1_i(strobe1), .value1_i(value1), .tx_o(tx), .idle_o(idle)
  );

  debug_hex_monitor #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_monitor (
    .clk_i(clk), .reset_i(reset), .tx_i(tx), .idle_i(idle), .quiet_i(quiet)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Hard stop when reports stop coming
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, %0d reports never arrived",
               cycle_count, u_monitor.pending());
      $display("Something failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Channel digit, separator, eight upper case digits from the top nibble down
  function automatic string expected_line(input int ch, input logic [31:0] v, input bit ovr);
    string hex_chars;
    string s;
    hex_chars = "0123456789ABCDEF";
    s = $sformatf("%0d%s", ch, ovr ? "!" : ":");
    for (int i = 7; i >= 0; i--) begin
      s = $sformatf("%s%c", s, hex_chars[v[4*i +: 4]]);
    end
    return s;
  endfunction

  initial begin : stimulus
    int          fd;
    int          code;
    int          w;
    int          c;
    logic [31:0] v;
    string       line;
    string       tag;
    int          waits[$];
    int          chans[$];
    logic [31:0] vals[$];
    string       tags[$];
    logic [31:0] rnd;
    int          gap;
    strobe0 = 1'b0;
    value0  = '0;
    strobe1 = 1'b0;
    value1  = '0;
    quiet   = 1'b0;
    reset   = 1'b1;
    fd = $fopen("testbench/debug_hex_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file testbench/debug_hex_input.txt");
      file_errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        // Skip comments and empty lines
        if (code > 1 && line[0] != "#") begin
          if ($sscanf(line, "%d %d %h %s", w, c, v, tag) == 4) begin
            waits.push_back(w);
            chans.push_back(c);
            vals.push_back(v);
            tags.push_back(tag);
          end else begin
            $display("Stimulus line not understood: %s", line);
            file_errors++;
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = ((waits.size() > 0) ? waits.size() : 1) * 15 * REPORT_CYCLES;

    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // Wait 0 puts an event on the same edge as the one before
    foreach (waits[i]) begin
      repeat (waits[i]) begin
        @(posedge clk);
        strobe0 <= 1'b0;
        strobe1 <= 1'b0;
      end
      if (chans[i] == 0) begin
        strobe0 <= 1'b1;
        value0  <= vals[i];
      end else begin
        strobe1 <= 1'b1;
        value1  <= vals[i];
      end
      // Superseded values must never show up on the line
      if (tags[i] != "S") begin
        u_monitor.push_expected(chans[i] != 0, expected_line(chans[i], vals[i], tags[i] == "1"));
      end
    end
    @(posedge clk);
    strobe0 <= 1'b0;
    strobe1 <= 1'b0;

    while (u_monitor.pending() != 0 || !idle) @(posedge clk);
    rnd = lcg_next(SEED);
    gap = 50 + int'((rnd >> 8) % 32'd150);
    quiet <= 1'b1;
    repeat (gap) @(posedge clk);
    quiet <= 1'b0;

    total_errors = u_monitor.error_count + file_errors + u_debug_hex_top.u_checker.fail_count;
    $display("Summary: %0d lines, %0d mismatches, %0d assertion failures, %0d stimulus errors",
             u_monitor.line_count, u_monitor.error_count,
             u_debug_hex_top.u_checker.fail_count, file_errors);
    if (total_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
